//--- hw/cart_pkg.sv
// Download stream and cartridge profile definitions
// Widths of the host download port, the decoded beat and the published profile

`default_nettype none

package cart_pkg;

	// ========================================================================
	// Download port widths
	// ========================================================================
	typedef logic [26:0] ioctl_addr_t;   // Byte address of the download
	typedef logic [15:0] ioctl_data_t;   // One 16-bit download word
	typedef logic [7:0]  image_index_t;  // Image index from the host menu
	typedef logic [1:0]  cart_type_t;    // Index bits 7:6
	typedef logic [24:0] pak_addr_t;     // Word address, byte address bits 26:2

	localparam image_index_t INDEX_BIOS  = 8'd0;    // BIOS image
	localparam image_index_t INDEX_CODES = 8'd255;  // Cheat-code file

	// One registered write of a cartridge download
	typedef struct packed {
		logic        start;  // First cycle of a cartridge download
		logic        valid;  // Cartridge word this cycle
		ioctl_addr_t addr;
		ioctl_data_t data;
	} cart_beat_t;

	// Result handed to the console core
	typedef struct packed {
		logic       loaded;        // A cartridge has been seen
		cart_type_t cart_type;
		logic       flash_1m;      // Signature found in image
		logic       sram_quirk;
		logic       remap_quirk;
		pak_addr_t  max_pak_addr;  // Highest word written
	} cart_profile_t;

endpackage

`default_nettype wire

//--- hw/quirk_pkg.sv
// Header-ID location, flash signature and the cartridge quirk table
// Every entry in the table forces the SRAM quirk, some also the remap

`default_nettype none

package quirk_pkg;

	typedef logic [95:0] cart_id_t;  // 12 ASCII bytes, first char on top

	// ========================================================================
	// Header layout
	// ========================================================================
	localparam logic [22:0] HDR_LINE      = 23'hA;  // Line 'hA0..'hAF of the image
	localparam logic [3:0]  HDR_CHECK_OFS = 4'd12;  // ID complete at this offset

	// Backup type marker, searched anywhere in the image
	localparam logic [71:0] FLASH_SIG = "FLASH1M_V";

	// ========================================================================
	// Quirk table
	// ========================================================================
	localparam int QUIRK_COUNT = 5;

	// Short names are zero padded on the right
	localparam cart_id_t QUIRK_IDS [QUIRK_COUNT] = '{
		"ROCKY BOXING",            // Boxing title
		"DBZ LGCYGOKU",            // Fighting title
		{"IRIDIONII", 24'h000000}, // Shooter, both regions
		{"SUPER MARIO", 8'h00},    // NES reissue
		{"ZELDA 1", 40'h0}         // NES reissue
	};

	// Remap bit per entry, bit i belongs to QUIRK_IDS[i]
	localparam logic [QUIRK_COUNT-1:0] QUIRK_REMAP = 5'b11000;  // NES reissues only

endpackage

`default_nettype wire

//--- hw/download_decode.sv
// Download decoder
// Classifies the image index, registers the write stream
// and marks cartridge start and end

`timescale 1ns/1ps
`default_nettype none

module download_decode import cart_pkg::*; (
	input  wire logic         clk_sys,
	input  wire logic         reset,
	input  wire logic         ioctl_download,
	input  wire image_index_t ioctl_index,
	input  wire logic         ioctl_wr,
	input  wire ioctl_addr_t  ioctl_addr,
	input  wire ioctl_data_t  ioctl_data,
	output cart_beat_t        beat,
	output logic              cart_end,
	output cart_type_t        cart_type
);

	logic        is_cart;    // Cartridge image being sent right now
	logic        cart_dl;    // Registered cartridge flag
	logic        cart_dl_d;  // Previous value for edge detect
	logic        wr_q;       // Registered write strobe
	ioctl_addr_t addr_q;
	ioctl_data_t data_q;

	// BIOS and cheat codes never reach the detectors
	assign is_cart = ioctl_download && (ioctl_index != INDEX_BIOS) &&
		(ioctl_index != INDEX_CODES);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_dl   <= 1'b0;
			cart_dl_d <= 1'b0;
			wr_q      <= 1'b0;
		end else begin
			cart_dl   <= is_cart;
			cart_dl_d <= cart_dl;
			wr_q      <= ioctl_wr && is_cart;  // Same stage as cart_dl
		end
	end

	// Payload follows the strobe, no reset
	always_ff @(posedge clk_sys) begin
		if (ioctl_wr) begin
			addr_q <= ioctl_addr;
			data_q <= ioctl_data;
		end
	end

	// Type comes from the index, stable for the whole download
	always_ff @(posedge clk_sys) begin
		if (reset)
			cart_type <= '0;
		else if (beat.start)
			cart_type <= ioctl_index[7:6];
	end

	always_comb begin
		beat.start = cart_dl && !cart_dl_d;  // Rising edge of the flag
		beat.valid = wr_q;
		beat.addr  = addr_q;
		beat.data  = data_q;
		cart_end   = cart_dl_d && !cart_dl;  // Falling edge
	end

endmodule

`default_nettype wire

//--- hw/flash_sig_detect.sv
// Flash signature detector
// Sliding byte window over the cartridge stream, checked at both
// byte alignments of every incoming word

`timescale 1ns/1ps
`default_nettype none

module flash_sig_detect import cart_pkg::*, quirk_pkg::*; (
	input  wire logic       clk_sys,
	input  wire logic       reset,
	input  wire cart_beat_t beat,
	output logic            flash_hit
);

	logic [63:0] window;   // Last 8 bytes, oldest byte on top
	logic [63:0] win_cur;  // Window as this beat sees it
	logic [7:0]  byte_lo;  // Even address, comes first
	logic [7:0]  byte_hi;
	logic        hit_lo;   // Signature ends on the low byte
	logic        hit_hi;   // Signature ends on the high byte

	always_comb begin
		byte_lo = beat.data[7:0];
		byte_hi = beat.data[15:8];
		win_cur = beat.start ? '0 : window;  // Nothing carried over from the last image
		hit_lo  = ({win_cur, byte_lo} == FLASH_SIG);
		hit_hi  = ({win_cur[55:0], byte_lo, byte_hi} == FLASH_SIG);
	end

	// Shift in two bytes per word
	always_ff @(posedge clk_sys) begin
		if (beat.valid)
			window <= {win_cur[47:0], byte_lo, byte_hi};
		else if (beat.start)
			window <= '0;
	end

	// Sticky until the next cartridge starts
	always_ff @(posedge clk_sys) begin
		if (reset)
			flash_hit <= 1'b0;
		else if (beat.valid && (hit_lo || hit_hi))
			flash_hit <= 1'b1;  // Wins over a start in the same beat
		else if (beat.start)
			flash_hit <= 1'b0;
	end

endmodule

`default_nettype wire

//--- hw/quirk_id_match.sv
// Header-ID matcher
// Gathers the 12-byte game ID from the cartridge header and looks it up
// in the quirk table to set the SRAM and remap quirks

`timescale 1ns/1ps
`default_nettype none

module quirk_id_match import cart_pkg::*, quirk_pkg::*; (
	input  wire logic       clk_sys,
	input  wire logic       reset,
	input  wire cart_beat_t beat,
	output logic            sram_quirk,
	output logic            remap_quirk
);

	cart_id_t               cart_id;   // Collected ID, first char in bits 95:88
	logic [3:0]             line_ofs;  // Byte offset inside the header line
	logic                   in_line;   // Beat lands in the ID line
	logic [6:0]             slot_lsb;  // Bit position of this word in cart_id
	logic [QUIRK_COUNT-1:0] id_match;  // One bit per table entry

	// ========================================================================
	// Decode and table lookup
	// ========================================================================
	always_comb begin
		line_ofs = beat.addr[3:0];
		in_line  = beat.valid && (beat.addr[26:4] == HDR_LINE);
		slot_lsb = {4'd10 - line_ofs, 3'd0};  // Offset 0 goes to the top word
		for (int i = 0; i < QUIRK_COUNT; i++) begin
			id_match[i] = (cart_id == QUIRK_IDS[i]);
		end
	end

	// Byte swap, the low byte holds the earlier character
	always_ff @(posedge clk_sys) begin
		if (in_line && (line_ofs < HDR_CHECK_OFS))
			cart_id[slot_lsb +: 16] <= {beat.data[7:0], beat.data[15:8]};
	end

	// ========================================================================
	// Quirk flags
	// ========================================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			sram_quirk  <= 1'b0;
			remap_quirk <= 1'b0;
		end else if (in_line && (line_ofs == HDR_CHECK_OFS)) begin
			sram_quirk  <= |id_match;                  // Every entry wants SRAM
			remap_quirk <= |(id_match & QUIRK_REMAP);
		end else if (beat.start) begin
			sram_quirk  <= 1'b0;                       // New image, forget old ID
			remap_quirk <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- hw/cart_profile.sv
// Profile stage
// Tracks the last written address and publishes the combined
// cartridge profile when the download ends

`timescale 1ns/1ps
`default_nettype none

module cart_profile import cart_pkg::*; (
	input  wire logic       clk_sys,
	input  wire logic       reset,
	input  wire cart_beat_t beat,
	input  wire logic       cart_end,
	input  wire cart_type_t cart_type,
	input  wire logic       flash_hit,
	input  wire logic       sram_quirk,
	input  wire logic       remap_quirk,
	output cart_profile_t   profile,
	output logic            profile_valid
);

	ioctl_addr_t last_addr;  // Address of the most recent word
	logic        capture_d;  // Profile taken last cycle

	// Running last address, restarted with each cartridge
	always_ff @(posedge clk_sys) begin
		if (beat.valid)
			last_addr <= beat.addr;
		else if (beat.start)
			last_addr <= '0;
	end

	// ========================================================================
	// Capture and publish
	// ========================================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			profile       <= '0;
			profile_valid <= 1'b0;
			capture_d     <= 1'b0;
		end else begin
			capture_d <= cart_end;
			if (cart_end) begin
				profile.loaded       <= 1'b1;
				profile.cart_type    <= cart_type;
				profile.flash_1m     <= flash_hit;
				profile.sram_quirk   <= sram_quirk;
				profile.remap_quirk  <= remap_quirk;
				profile.max_pak_addr <= last_addr[26:2];  // Byte to word address
			end
			if (beat.start)
				profile_valid <= 1'b0;  // Old profile stale from here
			else if (capture_d)
				profile_valid <= 1'b1;  // One cycle after capture
		end
	end

endmodule

`default_nettype wire

//--- hw/cart_inspect_top.sv
// Cartridge inspection top level
// Decoder feeding the signature detector, the ID matcher and the profile stage

`timescale 1ns/1ps
`default_nettype none

module cart_inspect_top import cart_pkg::*; (
	input  wire logic         clk_sys,
	input  wire logic         reset,
	input  wire logic         ioctl_download,
	input  wire image_index_t ioctl_index,
	input  wire logic         ioctl_wr,
	input  wire ioctl_addr_t  ioctl_addr,
	input  wire ioctl_data_t  ioctl_data,
	output cart_profile_t     profile,
	output logic              profile_valid
);

	cart_beat_t beat;         // Shared decoded stream
	logic       cart_end;
	cart_type_t cart_type;
	logic       flash_hit;
	logic       sram_quirk;
	logic       remap_quirk;

	download_decode u_decode (
		.clk_sys(clk_sys), .reset(reset),
		.ioctl_download(ioctl_download), .ioctl_index(ioctl_index),
		.ioctl_wr(ioctl_wr), .ioctl_addr(ioctl_addr), .ioctl_data(ioctl_data),
		.beat(beat), .cart_end(cart_end), .cart_type(cart_type)
	);

	flash_sig_detect u_flash (  // Signature anywhere in the image
		.clk_sys(clk_sys), .reset(reset), .beat(beat), .flash_hit(flash_hit)
	);

	quirk_id_match u_quirk (
		.clk_sys(clk_sys), .reset(reset), .beat(beat),
		.sram_quirk(sram_quirk), .remap_quirk(remap_quirk)
	);

	cart_profile u_profile (
		.clk_sys(clk_sys), .reset(reset), .beat(beat),
		.cart_end(cart_end), .cart_type(cart_type), .flash_hit(flash_hit),
		.sram_quirk(sram_quirk), .remap_quirk(remap_quirk),
		.profile(profile), .profile_valid(profile_valid)
	);

endmodule

`default_nettype wire

//--- test/tb_cart_inspect.sv
// Directed testbench for the cartridge inspection top level
// Stream driver, image builders, compare tasks and six directed tests

`timescale 1ns/1ps
`default_nettype none

module tb_cart_inspect import cart_pkg::*, quirk_pkg::*;;

	// ========================================================================
	// Run length, timeout and stimulus constants
	// ========================================================================
	localparam int total_words = 704;                   // Sum of all download lengths below
	localparam int cycle_limit = 2 * total_words + 200;
	localparam logic [71:0] sig_text = "FLASH1M_V";     // 1-Mbit flash marker

	logic          clk_sys = 1'b0;
	logic          reset;
	logic          ioctl_download;
	image_index_t  ioctl_index;
	logic          ioctl_wr;
	ioctl_addr_t   ioctl_addr;
	ioctl_data_t   ioctl_data;
	cart_profile_t profile;
	logic          profile_valid;

	ioctl_data_t   image [0:127];       // Words of the next download
	integer        seed = 32'h9d40_07bf;
	int            cycles = 0;
	int            type_errors = 0;
	int            addr_errors = 0;
	int            flag_errors = 0;
	logic          valid_dropped;       // profile_valid seen low while downloading

	cart_inspect_top UUT (
		.clk_sys(clk_sys), .reset(reset),
		.ioctl_download(ioctl_download), .ioctl_index(ioctl_index),
		.ioctl_wr(ioctl_wr), .ioctl_addr(ioctl_addr), .ioctl_data(ioctl_data),
		.profile(profile), .profile_valid(profile_valid)
	);

	always #10 clk_sys = ~clk_sys;  // 20 ns period

	always @(posedge clk_sys) begin
		cycles = cycles + 1;
		if (cycles > cycle_limit) begin
			$display("Timeout after %0d cycles, profile_valid did not rise in time", cycles);
			$display("Testbench failed");
			$finish;
		end
	end

	// ========================================================================
	// Compare tasks
	// ========================================================================
	task automatic check_type(input cart_type_t got, input cart_type_t exp);
		if (got !== exp) begin
			$display("error: profile.cart_type = %h, expected %h", got, exp);
			type_errors++;
		end
	endtask

	task automatic check_pak_addr(input pak_addr_t got, input pak_addr_t exp);
		if (got !== exp) begin
			$display("error: profile.max_pak_addr = %h, expected %h", got, exp);
			addr_errors++;
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string name);
		if (got !== exp) begin
			$display("error: %s = %h, expected %h", name, got, exp);
			flag_errors++;
		end
	endtask

	// ========================================================================
	// Image builders and stream driver
	// ========================================================================
	task automatic fill_image(input int count);
		int i;
		for (i = 0; i < count; i++)
			image[i] = ioctl_data_t'($random(seed)) | 16'h8080;  // Bit 7 set, never ASCII
	endtask

	task automatic put_byte(input int addr, input logic [7:0] value);
		if (addr[0])
			image[addr >> 1][15:8] = value;  // Odd byte in the high half
		else
			image[addr >> 1][7:0] = value;
	endtask

	task automatic place_id(input cart_id_t id);
		int k;
		for (k = 0; k < 12; k++)
			put_byte('hA0 + k, id[95 - 8 * k -: 8]);  // First char at 'hA0
	endtask

	task automatic place_sig(input int base);
		int k;
		for (k = 0; k < 9; k++)
			put_byte(base + k, sig_text[71 - 8 * k -: 8]);
	endtask

	// Called on a falling edge, leaves on one
	task automatic run_download(input image_index_t index, input int count);
		int i;
		int gap;
		valid_dropped  = 1'b0;
		ioctl_index    = index;
		ioctl_download = 1'b1;
		for (i = 0; i < count; i++) begin
			ioctl_wr   = 1'b1;
			ioctl_addr = ioctl_addr_t'(i * 2);
			ioctl_data = image[i];
			@(negedge clk_sys);
			ioctl_wr = 1'b0;
			gap = $unsigned($random(seed)) % 2;  // 0 or 1 idle cycles
			repeat (gap) @(negedge clk_sys);
			if (!profile_valid)
				valid_dropped = 1'b1;
		end
		repeat (2) @(negedge clk_sys);  // Download ends two cycles after last write
		ioctl_download = 1'b0;
	endtask

	task automatic wait_profile();
		while (!profile_valid)
			@(negedge clk_sys);  // Three cycles after download falls
	endtask

	task automatic expect_profile(input cart_type_t exp_type, input int count,
		input logic flash, input logic sram, input logic remap);
		check_flag(profile.loaded, 1'b1, "profile.loaded");
		check_type(profile.cart_type, exp_type);
		check_pak_addr(profile.max_pak_addr, pak_addr_t'(((count - 1) * 2) / 4));
		check_flag(profile.flash_1m, flash, "profile.flash_1m");
		check_flag(profile.sram_quirk, sram, "profile.sram_quirk");
		check_flag(profile.remap_quirk, remap, "profile.remap_quirk");
	endtask

	// ========================================================================
	// Directed tests
	// ========================================================================
	task automatic test_reset();
		check_flag(profile_valid, 1'b0, "profile_valid");
		check_flag(profile.loaded, 1'b0, "profile.loaded");
	endtask

	task automatic test_plain();
		fill_image(64);
		run_download(8'h40, 64);
		wait_profile();
		expect_profile(2'd1, 64, 1'b0, 1'b0, 1'b0);
	endtask

	task automatic test_flash(input int base);
		fill_image(64);
		place_sig(base);
		run_download(8'h40, 64);
		wait_profile();
		expect_profile(2'd1, 64, 1'b1, 1'b0, 1'b0);
	endtask

	task automatic test_quirk(input cart_id_t id, input logic sram, input logic remap);
		fill_image(96);  // Reaches past the header line
		place_id(id);
		run_download(8'h40, 96);
		wait_profile();
		expect_profile(2'd1, 96, 1'b0, sram, remap);
	endtask

	task automatic test_redownload();
		fill_image(96);
		place_id({"ZELDA 1", 40'h0});
		place_sig('h11);
		run_download(8'h40, 96);
		wait_profile();
		expect_profile(2'd1, 96, 1'b1, 1'b1, 1'b1);
		fill_image(64);  // Plain image, type 2
		run_download(8'h80, 64);
		check_flag(valid_dropped, 1'b1, "profile_valid low during download");
		wait_profile();
		expect_profile(2'd2, 64, 1'b0, 1'b0, 1'b0);
	endtask

	task automatic test_ignored(input image_index_t index);
		fill_image(32);
		place_sig('h07);  // Would set flash_1m if inspected
		run_download(index, 32);
		check_flag(valid_dropped, 1'b0, "profile_valid low during ignored download");
		repeat (5) @(negedge clk_sys);  // Beyond the 3-cycle publish latency
		check_flag(profile_valid, 1'b1, "profile_valid");
		expect_profile(2'd2, 64, 1'b0, 1'b0, 1'b0);  // Still the type 2 plain image
	endtask

	initial begin
		reset          = 1'b1;
		ioctl_download = 1'b0;
		ioctl_index    = '0;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_data     = '0;
		repeat (3) @(negedge clk_sys);  // Three reset cycles
		reset = 1'b0;
		test_reset();
		test_plain();
		test_flash('h20);  // Even alignment
		test_flash('h31);  // Odd alignment
		test_quirk("ROCKY BOXING", 1'b1, 1'b0);
		test_quirk({"ZELDA 1", 40'h0}, 1'b1, 1'b1);
		test_quirk("NOT IN TABLE", 1'b0, 1'b0);
		test_redownload();
		test_ignored(8'd0);    // BIOS
		test_ignored(8'd255);  // Cheat codes
		$display("Errors: cart_type %0d, pak_addr %0d, flag %0d",
			type_errors, addr_errors, flag_errors);
		if (type_errors + addr_errors + flag_errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb.f
hw/cart_pkg.sv
hw/quirk_pkg.sv
hw/download_decode.sv
hw/flash_sig_detect.sv
hw/quirk_id_match.sv
hw/cart_profile.sv
hw/cart_inspect_top.sv
test/tb_cart_inspect.sv
